// ==== logic/ppu_consts.svh ====
// Background renderer constants for screen geometry, VRAM layout and control bits
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Scaled-down screen, width must stay a multiple of the tile size
`define PPU_SCREEN_W 64
`define PPU_SCREEN_H 16

// Nametable 0 base and spacing between the two horizontal tables
`define PPU_NT_BASE 16'h2000
`define PPU_NT_SIZE 16'h0400
`define PPU_NT_COLS 32

// Pattern table 1 base, table 0 sits at address zero
`define PPU_PAT_BASE_HI 16'h1000

// Idle gap between rendered rows
`define PPU_HBLANK_CYCLES 4

// Control register bit positions
`define PPU_CTRL_NT_X 0
`define PPU_CTRL_PAT 4
`define PPU_CTRL_EN 7

`endif

// ==== logic/ppu_pkg.sv ====
// Shared types of the background renderer: vectors, config and write structs, FSM states
`default_nettype none

package ppu_pkg;

	typedef logic [7:0] ppu_byte_t;
	typedef logic [15:0] vram_addr_t;
	// Columns are two's complement so a chunk may start left of the screen
	typedef logic [8:0] screen_coord_t;
	typedef logic [1:0] pixel_t;

	// CPU register select
	typedef enum logic [1:0] {
		reg_ctrl,
		reg_scroll_x,
		reg_scroll_y
	} cpu_reg_t;

	// Live configuration as latched at frame and row start
	typedef struct packed {
		logic en;
		logic nt_sel;
		logic pat_sel;
		ppu_byte_t scroll_x;
		ppu_byte_t scroll_y;
	} ppu_cfg_t;

	// One frame-buffer write
	typedef struct packed {
		screen_coord_t row;
		screen_coord_t col;
		pixel_t pixel;
	} fb_write_t;

	typedef enum logic [2:0] {
		render_idle,
		render_row_start,
		render_tile_start,
		render_tile_wait,
		render_hblank,
		render_frame_end
	} render_state_t;

	typedef enum logic [2:0] {
		fetch_idle,
		fetch_rd_name,
		fetch_rd_plane0,
		fetch_rd_plane1,
		fetch_emit
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== logic/ppu_regs.sv ====
// Register block of the renderer: CPU control and scroll, config latching, vblank status
`timescale 1ns/1ps
`default_nettype none
`include "ppu_consts.svh"

module ppu_regs
	import ppu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      cpu_we,
	input  cpu_reg_t  cpu_sel,
	input  ppu_byte_t cpu_wdata,
	input  logic      cpu_rd,
	output ppu_byte_t status,
	input  logic      latch_frame,
	input  logic      latch_row,
	input  logic      set_vblank,
	output ppu_cfg_t  cfg
);

	// CPU-side copies, not seen by the renderer until latched
	ppu_byte_t ctrl_q;
	ppu_byte_t scroll_x_q;
	ppu_byte_t scroll_y_q;
	// Sticky end-of-frame flag
	logic vblank;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ctrl_q <= '0;
			scroll_x_q <= '0;
			scroll_y_q <= '0;
		end else if (cpu_we) begin
			case (cpu_sel)
				reg_ctrl: ctrl_q <= cpu_wdata;
				reg_scroll_x: scroll_x_q <= cpu_wdata;
				reg_scroll_y: scroll_y_q <= cpu_wdata;
				default: ctrl_q <= ctrl_q;
			endcase
		end
	end

	// Frame strobe takes enable, pattern table and vertical scroll
	// Row strobe takes horizontal scroll and nametable select
	// A write in the strobe cycle only shows up on the next strobe
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg <= '0;
		end else begin
			if (latch_frame) begin
				cfg.en <= ctrl_q[`PPU_CTRL_EN];
				cfg.pat_sel <= ctrl_q[`PPU_CTRL_PAT];
				cfg.scroll_y <= scroll_y_q;
			end
			if (latch_row) begin
				cfg.nt_sel <= ctrl_q[`PPU_CTRL_NT_X];
				cfg.scroll_x <= scroll_x_q;
			end
		end
	end

	// Status read snapshots vblank into bit 7 and clears it
	// A set in the same cycle wins over the clear
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vblank <= 1'b0;
			status <= '0;
		end else begin
			if (set_vblank)
				vblank <= 1'b1;
			else if (cpu_rd)
				vblank <= 1'b0;
			if (cpu_rd)
				status <= {vblank, 7'b0};
		end
	end

	// Frame end and a new frame start are separate sequencer states
	a_vblank_vs_frame: assert property (@(posedge clk) disable iff (!rst)
		!(set_vblank && latch_frame));

endmodule

`default_nettype wire

// ==== logic/ppu_render_fsm.sv ====
// Frame and row sequencer stepping 8-pixel tile chunks across each row, vblank at frame end
`timescale 1ns/1ps
`default_nettype none
`include "ppu_consts.svh"

module ppu_render_fsm
	import ppu_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          frame_start,
	input  ppu_cfg_t      cfg,
	output logic          latch_frame,
	output logic          latch_row,
	output logic          set_vblank,
	output logic          tile_start,
	output screen_coord_t tile_row,
	output screen_coord_t tile_col,
	input  logic          tile_done
);

	render_state_t state;
	// Column of the chunk after the current one
	screen_coord_t next_col;
	logic last_chunk;
	logic last_row;
	logic [3:0] hb_cnt;
	logic hb_done;

	// Next column is never negative, so an unsigned compare finds the row end
	// Fine scroll adds one extra chunk through the negative start
	assign next_col = tile_col + screen_coord_t'(8);
	assign last_chunk = next_col >= screen_coord_t'(`PPU_SCREEN_W);
	assign last_row = tile_row == screen_coord_t'(`PPU_SCREEN_H - 1);
	assign hb_done = hb_cnt == 4'(`PPU_HBLANK_CYCLES - 1);

	// Latch strobes fire on the transition into row_start
	// so the new config is already live in row_start
	assign latch_frame = (state == render_idle) && frame_start;
	assign latch_row = latch_frame || ((state == render_hblank) && hb_done);

	assign tile_start = state == render_tile_start;
	assign set_vblank = state == render_frame_end;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= render_idle;
			tile_row <= '0;
			tile_col <= '0;
			hb_cnt <= '0;
		end else begin
			case (state)
				render_idle: begin
					// Strobes arriving mid-frame never reach here
					if (frame_start) begin
						tile_row <= '0;
						state <= render_row_start;
					end
				end
				render_row_start: begin
					// Enable only just latched, drop the frame if clear
					if (!cfg.en) begin
						state <= render_idle;
					end else begin
						// Row starts at minus the fine scroll
						tile_col <= screen_coord_t'(0) - screen_coord_t'(cfg.scroll_x[2:0]);
						state <= render_tile_start;
					end
				end
				render_tile_start: begin
					state <= render_tile_wait;
				end
				render_tile_wait: begin
					if (tile_done) begin
						if (!last_chunk) begin
							// Next chunk strobes one cycle after tile_done
							tile_col <= next_col;
							state <= render_tile_start;
						end else if (last_row) begin
							state <= render_frame_end;
						end else begin
							hb_cnt <= '0;
							state <= render_hblank;
						end
					end
				end
				render_hblank: begin
					if (hb_done) begin
						tile_row <= tile_row + screen_coord_t'(1);
						state <= render_row_start;
					end else begin
						hb_cnt <= hb_cnt + 4'd1;
					end
				end
				render_frame_end: begin
					// vblank goes out this cycle
					state <= render_idle;
				end
				default: begin
					state <= render_idle;
				end
			endcase
		end
	end

	// Fetcher must only finish a chunk that this sequencer is waiting on
	a_done_in_wait: assert property (@(posedge clk) disable iff (!rst)
		tile_done |-> state == render_tile_wait);

endmodule

`default_nettype wire

// ==== logic/ppu_tile_fetch.sv ====
// Tile fetcher: VRAM nametable and pattern reads for one chunk, then eight pixel writes
`timescale 1ns/1ps
`default_nettype none
`include "ppu_consts.svh"

module ppu_tile_fetch
	import ppu_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  ppu_cfg_t      cfg,
	input  logic          tile_start,
	input  screen_coord_t tile_row,
	input  screen_coord_t tile_col,
	output logic          tile_done,
	output vram_addr_t    vram_addr,
	output logic          vram_rd,
	input  ppu_byte_t     vram_data,
	output fb_write_t     fb,
	output logic          fb_we
);

	fetch_state_t state;
	// 0 is the plane 1 capture cycle, 1 to 8 are pixel cycles
	logic [3:0] pix_cnt;
	ppu_byte_t name_q;
	ppu_byte_t p0_q;
	ppu_byte_t p1_q;
	screen_coord_t pos_x;
	screen_coord_t pos_y;
	logic nt_hi;
	ppu_byte_t tile_idx;
	vram_addr_t name_addr;
	vram_addr_t pat_base;
	vram_addr_t plane0_addr;
	logic [2:0] px_ofs;
	screen_coord_t px_col;

	// Scrolled position of the chunk, chunk start is always tile aligned in x
	assign pos_x = screen_coord_t'(cfg.scroll_x) + tile_col;
	assign pos_y = screen_coord_t'(cfg.scroll_y) + tile_row;
	// Carry out of x crosses into the other horizontal table
	assign nt_hi = pos_x[8] ^ cfg.nt_sel;

	assign name_addr = `PPU_NT_BASE
		+ (nt_hi ? `PPU_NT_SIZE : vram_addr_t'(0))
		+ vram_addr_t'(pos_y[8:3]) * vram_addr_t'(`PPU_NT_COLS)
		+ vram_addr_t'(pos_x[7:3]);

	// Tile byte is on the bus during rd_plane0, held afterwards
	assign tile_idx = (state == fetch_rd_plane0) ? vram_data : name_q;
	assign pat_base = cfg.pat_sel ? `PPU_PAT_BASE_HI : vram_addr_t'(0);
	assign plane0_addr = pat_base + vram_addr_t'({tile_idx, 4'b0000}) + vram_addr_t'(pos_y[2:0]);

	assign vram_rd = (state == fetch_rd_name) || (state == fetch_rd_plane0) ||
		(state == fetch_rd_plane1);

	always_comb begin
		case (state)
			fetch_rd_plane0: vram_addr = plane0_addr;
			fetch_rd_plane1: vram_addr = plane0_addr + vram_addr_t'(8);
			default: vram_addr = name_addr;
		endcase
	end

	// Pixel k of the chunk sits at column tile_col + k
	assign px_ofs = pix_cnt[2:0] - 3'd1;
	assign px_col = tile_col + screen_coord_t'(px_ofs);

	// MSB of each plane is the leftmost pixel
	assign fb = '{row: tile_row, col: px_col, pixel: {p1_q[7], p0_q[7]}};
	// Off-screen columns (negative or past the right edge) are dropped
	assign fb_we = (state == fetch_emit) && (pix_cnt != 4'd0) && !px_col[8] &&
		(px_col < screen_coord_t'(`PPU_SCREEN_W));
	assign tile_done = (state == fetch_emit) && (pix_cnt == 4'd8);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= fetch_idle;
			pix_cnt <= '0;
		end else begin
			case (state)
				fetch_idle: if (tile_start) state <= fetch_rd_name;
				fetch_rd_name: state <= fetch_rd_plane0;
				fetch_rd_plane0: state <= fetch_rd_plane1;
				fetch_rd_plane1: begin
					pix_cnt <= '0;
					state <= fetch_emit;
				end
				fetch_emit: begin
					if (pix_cnt == 4'd8)
						state <= fetch_idle;
					else
						pix_cnt <= pix_cnt + 4'd1;
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	// VRAM bytes land one cycle after each read
	always_ff @(posedge clk) begin
		case (state)
			fetch_rd_plane0: name_q <= vram_data;
			fetch_rd_plane1: p0_q <= vram_data;
			fetch_emit: begin
				if (pix_cnt == 4'd0) begin
					p1_q <= vram_data;
				end else begin
					p0_q <= p0_q << 1;
					p1_q <= p1_q << 1;
				end
			end
			default: name_q <= name_q;
		endcase
	end

	// Sequencer must wait for tile_done before the next chunk
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst)
		tile_start |-> state == fetch_idle);

endmodule

`default_nettype wire

// ==== logic/ppu_top.sv ====
// Background renderer top: registers, sequencer and tile fetcher on VRAM and frame-buffer ports
`timescale 1ns/1ps
`default_nettype none

module ppu_top
	import ppu_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cpu_we,
	input  cpu_reg_t   cpu_sel,
	input  ppu_byte_t  cpu_wdata,
	input  logic       cpu_rd,
	output ppu_byte_t  status,
	input  logic       frame_start,
	output vram_addr_t vram_addr,
	output logic       vram_rd,
	input  ppu_byte_t  vram_data,
	output fb_write_t  fb,
	output logic       fb_we
);

	// Live config shared by sequencer and fetcher
	ppu_cfg_t cfg;
	logic latch_frame;
	logic latch_row;
	logic set_vblank;
	// Chunk handshake
	logic tile_start;
	logic tile_done;
	screen_coord_t tile_row;
	screen_coord_t tile_col;

	ppu_regs ppu_regs_i (
		.clk         (clk),
		.rst         (rst),
		.cpu_we      (cpu_we),
		.cpu_sel     (cpu_sel),
		.cpu_wdata   (cpu_wdata),
		.cpu_rd      (cpu_rd),
		.status      (status),
		.latch_frame (latch_frame),
		.latch_row   (latch_row),
		.set_vblank  (set_vblank),
		.cfg         (cfg)
	);

	ppu_render_fsm ppu_render_fsm_i (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.cfg         (cfg),
		.latch_frame (latch_frame),
		.latch_row   (latch_row),
		.set_vblank  (set_vblank),
		.tile_start  (tile_start),
		.tile_row    (tile_row),
		.tile_col    (tile_col),
		.tile_done   (tile_done)
	);

	// Fetcher owns the VRAM port and the frame-buffer port
	ppu_tile_fetch ppu_tile_fetch_i (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.tile_start (tile_start),
		.tile_row   (tile_row),
		.tile_col   (tile_col),
		.tile_done  (tile_done),
		.vram_addr  (vram_addr),
		.vram_rd    (vram_rd),
		.vram_data  (vram_data),
		.fb         (fb),
		.fb_we      (fb_we)
	);

endmodule

`default_nettype wire

// ==== tb/ppu_tb.sv ====
// Testbench of the background renderer: VRAM model, file-driven frames, reference pixels, checks
`timescale 1ns/1ps
`default_nettype none
`include "ppu_consts.svh"

module ppu_tb
	import ppu_pkg::*;
();

	localparam int FB_SIZE = `PPU_SCREEN_W * `PPU_SCREEN_H;
	// Each poll is one status read of two cycles
	localparam int VBLANK_POLLS = 2500;

	logic clk;
	logic rst;
	logic cpu_we;
	cpu_reg_t cpu_sel;
	ppu_byte_t cpu_wdata;
	logic cpu_rd;
	ppu_byte_t status;
	logic frame_start;
	vram_addr_t vram_addr;
	logic vram_rd;
	ppu_byte_t vram_data;
	fb_write_t fb;
	logic fb_we;

	// VRAM copy shared by the model and the reference
	ppu_byte_t vram [0:65535];
	// Shadow frame buffer with the number of the frame that last wrote each pixel
	pixel_t shadow [0:FB_SIZE-1];
	int tag [0:FB_SIZE-1];
	int frame_no;
	int wr_count;
	int seed;
	logic [9:0] cap_idx;

	ppu_top ppu_top_i (
		.clk         (clk),
		.rst         (rst),
		.cpu_we      (cpu_we),
		.cpu_sel     (cpu_sel),
		.cpu_wdata   (cpu_wdata),
		.cpu_rd      (cpu_rd),
		.status      (status),
		.frame_start (frame_start),
		.vram_addr   (vram_addr),
		.vram_rd     (vram_rd),
		.vram_data   (vram_data),
		.fb          (fb),
		.fb_we       (fb_we)
	);

	always #50 clk = ~clk;

	// Synchronous VRAM with data one cycle after the read strobe
	always @(posedge clk) begin
		if (vram_rd)
			vram_data <= vram[vram_addr];
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("FAILED at %0t: %s, got %0d expected %0d", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Capture every write and check its range and uniqueness on the spot
	always @(negedge clk) begin
		if (rst && fb_we) begin
			if (fb.row >= 9'(`PPU_SCREEN_H) || fb.col >= 9'(`PPU_SCREEN_W)) begin
				abort_run($sformatf("Frame-buffer write out of range at row %0d col %0d",
					fb.row, fb.col));
			end else begin
				cap_idx = 10'(int'(fb.row) * `PPU_SCREEN_W + int'(fb.col));
				if (tag[cap_idx] == frame_no)
					abort_run($sformatf("Pixel at row %0d col %0d written twice",
						fb.row, fb.col));
				tag[cap_idx] = frame_no;
				shadow[cap_idx] = fb.pixel;
				wr_count++;
			end
		end
	end

	// Reference pixel from the scroll, nametable and bitplane rule
	function automatic pixel_t ref_pixel(input int row, input int col, input ppu_byte_t ctrl,
		input ppu_byte_t sx, input ppu_byte_t sy);
		int x;
		int y;
		int nt;
		logic [15:0] name_addr;
		logic [15:0] p0_addr;
		logic [2:0] bit_i;
		x = int'(sx) + col;
		y = int'(sy) + row;
		// Carry past 255 flips to the other table
		nt = ((x >> 8) & 1) ^ int'(ctrl[`PPU_CTRL_NT_X]);
		name_addr = 16'(int'(`PPU_NT_BASE) + nt * int'(`PPU_NT_SIZE)
			+ (y / 8) * `PPU_NT_COLS + (x % 256) / 8);
		p0_addr = 16'((ctrl[`PPU_CTRL_PAT] ? int'(`PPU_PAT_BASE_HI) : 0)
			+ int'(vram[name_addr]) * 16 + y % 8);
		// Leftmost pixel is the MSB
		bit_i = 3'(7 - x % 8);
		return {vram[p0_addr + 16'd8][bit_i], vram[p0_addr][bit_i]};
	endfunction

	task automatic cpu_write(input cpu_reg_t sel, input ppu_byte_t data);
		@(posedge clk);
		cpu_we <= 1'b1;
		cpu_sel <= sel;
		cpu_wdata <= data;
		@(posedge clk);
		cpu_we <= 1'b0;
	endtask

	// Status lands one edge after the strobe is seen
	task automatic status_read(output ppu_byte_t value);
		@(posedge clk);
		cpu_rd <= 1'b1;
		@(posedge clk);
		cpu_rd <= 1'b0;
		@(negedge clk);
		value = status;
	endtask

	task automatic wait_vblank(output logic seen);
		ppu_byte_t st;
		int polls;
		seen = 1'b0;
		polls = 0;
		while (!seen && polls < VBLANK_POLLS) begin
			status_read(st);
			seen = st[7];
			polls++;
		end
	endtask

	task automatic run_frame(input ppu_byte_t ctrl, input ppu_byte_t sx, input ppu_byte_t sy,
		input int second_rd, input int exp_writes);
		int start_count;
		logic seen;
		ppu_byte_t st;
		frame_no++;
		start_count = wr_count;
		cpu_write(reg_ctrl, ctrl);
		cpu_write(reg_scroll_x, sx);
		cpu_write(reg_scroll_y, sy);
		@(posedge clk);
		frame_start <= 1'b1;
		@(posedge clk);
		frame_start <= 1'b0;
		wait_vblank(seen);
		if (exp_writes != 0) begin
			if (!seen)
				abort_run($sformatf("Timed out waiting for vblank in frame %0d", frame_no));
			check_value(wr_count - start_count, exp_writes, "frame-buffer write count");
			for (int i = 0; i < FB_SIZE; i++) begin
				check_value(tag[10'(i)], frame_no,
					$sformatf("pixel row %0d col %0d not written", i / `PPU_SCREEN_W,
					i % `PPU_SCREEN_W));
				check_value(int'(shadow[10'(i)]),
					int'(ref_pixel(i / `PPU_SCREEN_W, i % `PPU_SCREEN_W, ctrl, sx, sy)),
					$sformatf("pixel row %0d col %0d", i / `PPU_SCREEN_W, i % `PPU_SCREEN_W));
			end
			// Flag was cleared by the read that saw it
			if (second_rd != 0) begin
				status_read(st);
				check_value(int'(st[7]), 0, "vblank after second status read");
			end
		end else begin
			check_value(int'(seen), 0, "vblank on disabled frame");
			check_value(wr_count - start_count, 0, "writes on disabled frame");
		end
		$display("Frame %0d ctrl %h scroll %h/%h: %0d writes", frame_no, ctrl, sx, sy,
			wr_count - start_count);
	endtask

	initial begin
		int fd;
		string line;
		int n;
		logic [15:0] w_addr;
		ppu_byte_t w_data;
		ppu_byte_t f_ctrl;
		ppu_byte_t f_sx;
		ppu_byte_t f_sy;
		int f_rd;
		int f_exp;
		clk = 1'b0;
		rst = 1'b0;
		cpu_we = 1'b0;
		cpu_sel = reg_ctrl;
		cpu_wdata = '0;
		cpu_rd = 1'b0;
		frame_start = 1'b0;
		vram_data = '0;
		frame_no = 0;
		wr_count = 0;
		// Random background for every VRAM byte
		seed = 32'h397150f6;
		for (int i = 0; i < 65536; i++)
			vram[16'(i)] = 8'($random(seed));
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		fd = $fopen("tb/ppu_stimulus.txt", "r");
		if (fd == 0)
			abort_run("Cannot open tb/ppu_stimulus.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end else if (line.getc(0) == "w") begin
				n = $sscanf(line, "w %h %h", w_addr, w_data);
				if (n != 2)
					abort_run($sformatf("Bad VRAM record: %s", line));
				vram[w_addr] = w_data;
			end else if (line.getc(0) == "f") begin
				n = $sscanf(line, "f %h %h %h %d %d", f_ctrl, f_sx, f_sy, f_rd, f_exp);
				if (n != 5)
					abort_run($sformatf("Bad frame record: %s", line));
				run_frame(f_ctrl, f_sx, f_sy, f_rd, f_exp);
			end else begin
				abort_run($sformatf("Unknown record: %s", line));
			end
		end
		$fclose(fd);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/ppu_stimulus.txt ====
# w <vram addr hex> <byte hex> overwrites the random VRAM fill
# f <ctrl hex> <scroll_x hex> <scroll_y hex> <second status read 0/1> <expected writes>
w 2000 01
w 2001 02
w 2002 03
w 2020 04
w 201f 05
w 2400 06
w 2401 07
w 2420 01
w 0010 ff
w 0018 0f
w 0020 a5
w 0028 3c
w 1010 aa
w 1018 55
# zero scroll, fine scroll, crossing into table 1, swapped tables
f 80 00 00 1 1024
f 80 03 02 1 1024
f 80 fc 00 1 1024
f 81 fc 05 1 1024
# pattern table 1, then rendering disabled
f 90 05 04 1 1024
f 00 00 00 0 0

// ==== src.f ====
+incdir+logic
logic/ppu_pkg.sv
logic/ppu_regs.sv
logic/ppu_render_fsm.sv
logic/ppu_tile_fetch.sv
logic/ppu_top.sv
tb/ppu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ppu_tb -f src.f -Mdir obj_dir

output=$(./obj_dir/Vppu_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
